// ==== Makefile ====
SRCS := $(shell grep -v '^+' flist.f) source/cpu_defs.svh verif/tb_program.svh

obj_dir/Vtb_cpu_top: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top \
		-f flist.f -o Vtb_cpu_top

run: obj_dir/Vtb_cpu_top
	obj_dir/Vtb_cpu_top | tee sim.log
	grep -q "^TEST RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== flist.f ====
+incdir+source
+incdir+verif
source/cpu_pkg.sv
source/fetch_unit.sv
source/inst_queue.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/cpu_top.sv
verif/tb_cpu_top.sv

// ==== source/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////
// core sizing

`define CPU_RESET_PC     32'hbfc00000
`define CPU_QUEUE_DEPTH  4              // also the initial credit count
`define CPU_REG_COUNT    32

////////////////////
// opcode and funct fields

`define CPU_OP_SPECIAL   6'b000000
`define CPU_OP_ADDIU     6'b001001
`define CPU_OP_SLTI      6'b001010
`define CPU_OP_SLTIU     6'b001011
`define CPU_OP_ANDI      6'b001100
`define CPU_OP_ORI       6'b001101
`define CPU_OP_XORI      6'b001110
`define CPU_OP_LUI       6'b001111

`define CPU_FN_SLL       6'b000000
`define CPU_FN_SRL       6'b000010
`define CPU_FN_SRA       6'b000011
`define CPU_FN_ADDU      6'b100001
`define CPU_FN_SUBU      6'b100011
`define CPU_FN_AND       6'b100100
`define CPU_FN_OR        6'b100101
`define CPU_FN_XOR       6'b100110
`define CPU_FN_NOR       6'b100111
`define CPU_FN_SLT       6'b101010
`define CPU_FN_SLTU      6'b101011

`endif

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    ////////////////////
    // queue payload
    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_item_t;

    ////////////////////
    // decode to execute
    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   alu_op;
        word_t     a;
        word_t     b;      // also the shifted value for sll/srl/sra
        reg_addr_t dest;
        logic      wr;
    } decoded_t;

    typedef struct packed {
        logic      wen;
        word_t     pc;
        reg_addr_t wnum;
        word_t     wdata;
    } wb_info_t;

endpackage

// ==== source/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
    input  logic              clk,
    input  logic              resetn,
    input  logic              freeze,
    output logic              inst_sram_en,
    output cpu_pkg::word_t    inst_sram_addr,
    input  cpu_pkg::word_t    inst_sram_rdata,
    output cpu_pkg::wb_info_t debug_wb
);

    logic                 credit_return;
    logic                 push;
    cpu_pkg::fetch_item_t push_item;
    logic                 pop;
    logic                 not_empty;
    cpu_pkg::fetch_item_t head;
    cpu_pkg::reg_addr_t   raddr_a;
    cpu_pkg::reg_addr_t   raddr_b;
    cpu_pkg::word_t       rdata_a;
    cpu_pkg::word_t       rdata_b;
    logic                 we;
    cpu_pkg::reg_addr_t   waddr;
    cpu_pkg::word_t       wdata;
    logic                 fwd_valid;
    cpu_pkg::reg_addr_t   fwd_dest;
    cpu_pkg::word_t       fwd_data;
    cpu_pkg::decoded_t    decoded;

    ////////////////////
    // front end
    fetch_unit u_fetch (
        .clk             (clk),
        .resetn          (resetn),
        .credit_return   (credit_return),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .push            (push),
        .push_item       (push_item)
    );

    inst_queue u_queue (
        .clk           (clk),
        .resetn        (resetn),
        .push          (push),
        .push_item     (push_item),
        .pop           (pop),
        .not_empty     (not_empty),
        .head          (head),
        .credit_return (credit_return)
    );

    ////////////////////
    // back end
    decode_stage u_decode (
        .clk       (clk),
        .resetn    (resetn),
        .freeze    (freeze),
        .not_empty (not_empty),
        .head      (head),
        .pop       (pop),
        .raddr_a   (raddr_a),
        .raddr_b   (raddr_b),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b),
        .fwd_valid (fwd_valid),
        .fwd_dest  (fwd_dest),
        .fwd_data  (fwd_data),
        .decoded   (decoded)
    );

    reg_file u_regs (
        .clk     (clk),
        .resetn  (resetn),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    execute_stage u_execute (
        .clk       (clk),
        .resetn    (resetn),
        .decoded   (decoded),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .fwd_valid (fwd_valid),
        .fwd_dest  (fwd_dest),
        .fwd_data  (fwd_data),
        .debug_wb  (debug_wb)
    );

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 freeze,
    input  logic                 not_empty,
    input  cpu_pkg::fetch_item_t head,
    output logic                 pop,
    output cpu_pkg::reg_addr_t   raddr_a,
    output cpu_pkg::reg_addr_t   raddr_b,
    input  cpu_pkg::word_t       rdata_a,
    input  cpu_pkg::word_t       rdata_b,
    input  logic                 fwd_valid,
    input  cpu_pkg::reg_addr_t   fwd_dest,
    input  cpu_pkg::word_t       fwd_data,
    output cpu_pkg::decoded_t    decoded
);

    cpu_pkg::word_t     inst;
    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    logic [4:0]         shamt;
    cpu_pkg::word_t     imm_sext;
    cpu_pkg::word_t     imm_zext;
    cpu_pkg::word_t     src_a;
    cpu_pkg::word_t     src_b;
    cpu_pkg::decoded_t  dec_next;

    assign pop = not_empty && !freeze;  // freeze puts a bubble into execute

    assign inst     = head.inst;
    assign opcode   = inst[31:26];
    assign rs       = inst[25:21];
    assign rt       = inst[20:16];
    assign rd       = inst[15:11];
    assign shamt    = inst[10:6];
    assign funct    = inst[5:0];
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign imm_zext = {16'd0, inst[15:0]};

    assign raddr_a = rs;
    assign raddr_b = rt;

    ////////////////////
    // operand bypass from execute
    assign src_a = (fwd_valid && (rs != '0) && (rs == fwd_dest)) ? fwd_data : rdata_a;
    assign src_b = (fwd_valid && (rt != '0) && (rt == fwd_dest)) ? fwd_data : rdata_b;

    always_comb begin
        dec_next        = '0;
        dec_next.valid  = pop;
        dec_next.pc     = head.pc;
        dec_next.alu_op = cpu_pkg::alu_add;
        dec_next.a      = src_a;
        dec_next.b      = imm_sext;
        dec_next.dest   = rt;
        dec_next.wr     = 1'b1;
        case (opcode)
            `CPU_OP_SPECIAL: begin
                dec_next.b    = src_b;
                dec_next.dest = rd;
                case (funct)
                    `CPU_FN_ADDU: dec_next.alu_op = cpu_pkg::alu_add;
                    `CPU_FN_SUBU: dec_next.alu_op = cpu_pkg::alu_sub;
                    `CPU_FN_AND:  dec_next.alu_op = cpu_pkg::alu_and;
                    `CPU_FN_OR:   dec_next.alu_op = cpu_pkg::alu_or;
                    `CPU_FN_XOR:  dec_next.alu_op = cpu_pkg::alu_xor;
                    `CPU_FN_NOR:  dec_next.alu_op = cpu_pkg::alu_nor;
                    `CPU_FN_SLT:  dec_next.alu_op = cpu_pkg::alu_slt;
                    `CPU_FN_SLTU: dec_next.alu_op = cpu_pkg::alu_sltu;
                    `CPU_FN_SLL: begin
                        dec_next.alu_op = cpu_pkg::alu_sll;
                        dec_next.a      = {27'd0, shamt};
                    end
                    `CPU_FN_SRL: begin
                        dec_next.alu_op = cpu_pkg::alu_srl;
                        dec_next.a      = {27'd0, shamt};
                    end
                    `CPU_FN_SRA: begin
                        dec_next.alu_op = cpu_pkg::alu_sra;
                        dec_next.a      = {27'd0, shamt};
                    end
                    default: dec_next.wr = 1'b0;  // retires as a no-op
                endcase
            end
            `CPU_OP_ADDIU: dec_next.alu_op = cpu_pkg::alu_add;
            `CPU_OP_SLTI:  dec_next.alu_op = cpu_pkg::alu_slt;
            `CPU_OP_SLTIU: dec_next.alu_op = cpu_pkg::alu_sltu; // sign-extended imm
            `CPU_OP_ANDI: begin
                dec_next.alu_op = cpu_pkg::alu_and;
                dec_next.b      = imm_zext;
            end
            `CPU_OP_ORI: begin
                dec_next.alu_op = cpu_pkg::alu_or;
                dec_next.b      = imm_zext;
            end
            `CPU_OP_XORI: begin
                dec_next.alu_op = cpu_pkg::alu_xor;
                dec_next.b      = imm_zext;
            end
            `CPU_OP_LUI: begin
                dec_next.alu_op = cpu_pkg::alu_lui;
                dec_next.b      = imm_zext;
            end
            default: dec_next.wr = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            decoded <= '0;
        end else begin
            decoded <= dec_next;
        end
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::decoded_t  decoded,
    output logic               we,
    output cpu_pkg::reg_addr_t waddr,
    output cpu_pkg::word_t     wdata,
    output logic               fwd_valid,
    output cpu_pkg::reg_addr_t fwd_dest,
    output cpu_pkg::word_t     fwd_data,
    output cpu_pkg::wb_info_t  debug_wb
);

    cpu_pkg::word_t result;

    always_comb begin
        case (decoded.alu_op)
            cpu_pkg::alu_add:  result = decoded.a + decoded.b;
            cpu_pkg::alu_sub:  result = decoded.a - decoded.b;
            cpu_pkg::alu_and:  result = decoded.a & decoded.b;
            cpu_pkg::alu_or:   result = decoded.a | decoded.b;
            cpu_pkg::alu_xor:  result = decoded.a ^ decoded.b;
            cpu_pkg::alu_nor:  result = ~(decoded.a | decoded.b);
            cpu_pkg::alu_slt:  result = {31'd0, $signed(decoded.a) < $signed(decoded.b)};
            cpu_pkg::alu_sltu: result = {31'd0, decoded.a < decoded.b};
            cpu_pkg::alu_sll:  result = decoded.b << decoded.a[4:0];
            cpu_pkg::alu_srl:  result = decoded.b >> decoded.a[4:0];
            cpu_pkg::alu_sra:  result = $signed(decoded.b) >>> decoded.a[4:0];
            cpu_pkg::alu_lui:  result = {decoded.b[15:0], 16'd0};
            default:           result = '0;
        endcase
    end

    assign we    = decoded.valid && decoded.wr;
    assign waddr = decoded.dest;
    assign wdata = result;

    // result not yet in the register file
    assign fwd_valid = we;
    assign fwd_dest  = decoded.dest;
    assign fwd_data  = result;

    always_comb begin
        debug_wb.wen   = we;
        debug_wb.pc    = decoded.pc;
        debug_wb.wnum  = decoded.dest;
        debug_wb.wdata = result;
    end

    legal_alu_op_a: assert property (@(posedge clk) disable iff (!resetn)
        decoded.valid |-> (decoded.alu_op <= cpu_pkg::alu_lui))
        else $error("undefined alu function on a valid instruction");

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 credit_return,
    output logic                 inst_sram_en,
    output cpu_pkg::word_t       inst_sram_addr,
    input  cpu_pkg::word_t       inst_sram_rdata,
    output logic                 push,
    output cpu_pkg::fetch_item_t push_item
);

    localparam int credit_w = $clog2(`CPU_QUEUE_DEPTH + 1);

    cpu_pkg::word_t      pc;
    cpu_pkg::word_t      req_pc;   // pc of the word now on rdata
    logic [credit_w-1:0] credits;
    logic                run;      // first cycle out of reset
    logic                req_q;

    assign inst_sram_en   = run && (credits != '0);
    assign inst_sram_addr = pc;
    assign push           = req_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            run     <= 1'b0;
            req_q   <= 1'b0;
            pc      <= `CPU_RESET_PC;
            credits <= credit_w'(`CPU_QUEUE_DEPTH);
        end else begin
            run     <= 1'b1;
            req_q   <= inst_sram_en;
            credits <= credits - credit_w'(inst_sram_en) + credit_w'(credit_return);
            if (inst_sram_en) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_sram_en) begin
            req_pc <= pc;
        end
    end

    always_comb begin
        push_item.pc   = req_pc;
        push_item.inst = inst_sram_rdata; // sram answers one cycle later
    end

    // credits come back only for entries that were pushed
    credit_bound_a: assert property (@(posedge clk) disable iff (!resetn)
        credits <= credit_w'(`CPU_QUEUE_DEPTH))
        else $error("fetch credit count above queue depth");

endmodule

// ==== source/inst_queue.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module inst_queue #(
    parameter int depth = `CPU_QUEUE_DEPTH
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 push,
    input  cpu_pkg::fetch_item_t push_item,
    input  logic                 pop,
    output logic                 not_empty,
    output cpu_pkg::fetch_item_t head,
    output logic                 credit_return
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    cpu_pkg::fetch_item_t mem [depth];
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [cnt_w-1:0]     count;
    logic                 full;

    assign full          = (count == cnt_w'(depth));
    assign not_empty     = (count != '0);
    assign head          = mem[rd_ptr];
    assign credit_return = pop;         // one credit back per entry freed

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    ////////////////////
    // credit protocol checks
    no_overflow_a: assert property (@(posedge clk) disable iff (!resetn)
        push |-> !full)
        else $error("push into full instruction queue");

    no_underflow_a: assert property (@(posedge clk) disable iff (!resetn)
        pop |-> not_empty)
        else $error("pop from empty instruction queue");

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module reg_file (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::reg_addr_t raddr_a,
    input  cpu_pkg::reg_addr_t raddr_b,
    output cpu_pkg::word_t     rdata_a,
    output cpu_pkg::word_t     rdata_b,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

// ==== verif/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

cpu_pkg::word_t model_regs [`CPU_REG_COUNT];
cpu_pkg::word_t lcg_state;

function automatic cpu_pkg::word_t r_format(input logic [5:0] fn, input cpu_pkg::reg_addr_t rs,
        input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t rd, input logic [4:0] sa);
    return {`CPU_OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic cpu_pkg::word_t i_format(input logic [5:0] op, input cpu_pkg::reg_addr_t rs,
        input cpu_pkg::reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic cpu_pkg::word_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

////////////////////
// reference model, one instruction per call in program order

function automatic void model_retire(input cpu_pkg::word_t inst,
        output cpu_pkg::reg_addr_t wnum, output cpu_pkg::word_t wdata);
    cpu_pkg::word_t     s;
    cpu_pkg::word_t     t;
    cpu_pkg::word_t     sext;
    cpu_pkg::word_t     zext;
    logic signed [31:0] t_signed;
    s        = model_regs[inst[25:21]];
    t        = model_regs[inst[20:16]];
    t_signed = t;
    sext     = {{16{inst[15]}}, inst[15:0]};
    zext     = {16'h0000, inst[15:0]};
    wdata    = '0;
    if (inst[31:26] == `CPU_OP_SPECIAL) begin
        wnum = inst[15:11];
        case (inst[5:0])
            `CPU_FN_ADDU: wdata = s + t;
            `CPU_FN_SUBU: wdata = s - t;
            `CPU_FN_AND:  wdata = s & t;
            `CPU_FN_OR:   wdata = s | t;
            `CPU_FN_XOR:  wdata = s ^ t;
            `CPU_FN_NOR:  wdata = ~(s | t);
            `CPU_FN_SLT:  wdata = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
            `CPU_FN_SLTU: wdata = (s < t) ? 32'd1 : 32'd0;
            `CPU_FN_SLL:  wdata = t << inst[10:6];
            `CPU_FN_SRL:  wdata = t >> inst[10:6];
            `CPU_FN_SRA:  wdata = t_signed >>> inst[10:6];
            default:      wdata = '0;
        endcase
    end else begin
        wnum = inst[20:16];
        case (inst[31:26])
            `CPU_OP_ADDIU: wdata = s + sext;
            `CPU_OP_SLTI:  wdata = ($signed(s) < $signed(sext)) ? 32'd1 : 32'd0;
            `CPU_OP_SLTIU: wdata = (s < sext) ? 32'd1 : 32'd0;  // unsigned, imm sign-extended
            `CPU_OP_ANDI:  wdata = s & zext;
            `CPU_OP_ORI:   wdata = s | zext;
            `CPU_OP_XORI:  wdata = s ^ zext;
            `CPU_OP_LUI:   wdata = {inst[15:0], 16'h0000};
            default:       wdata = '0;
        endcase
    end
    if (wnum != '0) begin
        model_regs[wnum] = wdata;  // r0 keeps zero
    end
endfunction

`endif

// ==== verif/tb_cpu_top.sv ====
`timescale 1ns/1ns
`include "cpu_defs.svh"

module tb_cpu_top;

    logic              clk;
    logic              resetn;
    logic              freeze;
    logic              inst_sram_en;
    cpu_pkg::word_t    inst_sram_addr;
    cpu_pkg::word_t    inst_sram_rdata;
    cpu_pkg::wb_info_t debug_wb;

    cpu_pkg::word_t prog [128];
    int             prog_len;
    int             value_errors;
    int             flow_errors;
    int             timeouts;

    `include "tb_program.svh"

    cpu_top u_dut (
        .clk             (clk),
        .resetn          (resetn),
        .freeze          (freeze),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .debug_wb        (debug_wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic cpu_pkg::word_t fetch_word(input cpu_pkg::word_t addr);
        cpu_pkg::word_t offset;
        offset = addr - `CPU_RESET_PC;
        if (offset[1:0] != 2'b00 || offset[31:2] >= 30'(prog_len)) begin
            return '0;  // sll r0, r0, 0
        end
        return prog[offset[8:2]];
    endfunction

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= fetch_word(inst_sram_addr);  // synchronous sram
        end
    end

    task automatic add_inst(input cpu_pkg::word_t inst);
        prog[prog_len] = inst;
        prog_len++;
    endtask

    task automatic check_word(input string test, input string field,
            input cpu_pkg::word_t expected, input cpu_pkg::word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic check_reg(input string test, input cpu_pkg::reg_addr_t expected,
            input cpu_pkg::reg_addr_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %s wnum: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        resetn = 1'b0;
        freeze = 1'b0;
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(negedge clk);
        resetn = 1'b1;
    endtask

    ////////////////////
    // trace collection with freeze control

    task automatic collect_traces(input string test, input int count,
            input int frz_start, input int frz_len, input bit frz_random);
        int                 got;
        int                 cycle;
        int                 issued;
        int                 retired;
        cpu_pkg::reg_addr_t exp_num;
        cpu_pkg::word_t     exp_data;
        cpu_pkg::word_t     rnd;
        got     = 0;
        cycle   = 0;
        issued  = 0;
        retired = 0;
        while (got < count && cycle < 40 * count + 200) begin
            @(negedge clk);
            if (inst_sram_en) begin
                issued++;
            end
            if (debug_wb.wen) begin
                retired++;
                if (freeze) begin  // freeze here governed the last rising edge
                    flow_errors++;
                    $display("%s: a trace appeared while freeze was high", test);
                end
                model_retire(prog[got], exp_num, exp_data);
                check_word(test, "pc", `CPU_RESET_PC + 32'(4 * got), debug_wb.pc);
                check_reg(test, exp_num, debug_wb.wnum);
                check_word(test, "wdata", exp_data, debug_wb.wdata);
                got++;
            end
            if (issued - retired > `CPU_QUEUE_DEPTH + 1) begin
                flow_errors++;
                $display("%s: %0d fetched instructions not retired", test, issued - retired);
            end
            if (frz_random) begin
                rnd    = next_random();
                freeze = (rnd[17:16] == 2'b00);
            end else begin
                freeze = (cycle >= frz_start) && (cycle < frz_start + frz_len);
            end
            cycle++;
        end
        freeze = 1'b0;
        if (got < count) begin
            timeouts++;
            $display("%s: timed out with %0d of %0d traces seen", test, got, count);
        end
    endtask

    ////////////////////
    // directed tests

    task automatic reset_behavior();
        int wait_cycles;
        prog_len = 0;
        add_inst(i_format(`CPU_OP_ADDIU, 5'd0, 5'd1, 16'h0001));
        @(negedge clk);
        resetn = 1'b0;
        freeze = 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (debug_wb.wen !== 1'b0) begin
                flow_errors++;
                $display("reset: write-back trace active while reset is held");
            end
        end
        resetn = 1'b1;
        @(negedge clk);
        if (debug_wb.wen !== 1'b0) begin
            flow_errors++;
            $display("reset: write-back trace active on the first cycle after reset");
        end
        wait_cycles = 0;
        while (inst_sram_en !== 1'b1 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (inst_sram_en !== 1'b1) begin
            timeouts++;
            $display("reset: no fetch request seen after reset");
        end else begin
            check_word("reset", "first fetch address", `CPU_RESET_PC, inst_sram_addr);
        end
    endtask

    task automatic every_opcode();
        prog_len = 0;
        add_inst(i_format(`CPU_OP_LUI, 5'd0, 5'd1, 16'h8765));
        add_inst(i_format(`CPU_OP_ADDIU, 5'd1, 5'd1, 16'h4321));
        add_inst(i_format(`CPU_OP_ADDIU, 5'd0, 5'd2, 16'hfffb));  // -5
        add_inst(i_format(`CPU_OP_LUI, 5'd0, 5'd3, 16'h0f0f));
        add_inst(i_format(`CPU_OP_ADDIU, 5'd3, 5'd3, 16'h00f7));
        add_inst(r_format(`CPU_FN_ADDU, 5'd1, 5'd2, 5'd4, 5'd0));
        add_inst(r_format(`CPU_FN_SUBU, 5'd1, 5'd3, 5'd5, 5'd0));
        add_inst(r_format(`CPU_FN_AND, 5'd1, 5'd3, 5'd6, 5'd0));
        add_inst(r_format(`CPU_FN_OR, 5'd1, 5'd2, 5'd7, 5'd0));
        add_inst(r_format(`CPU_FN_XOR, 5'd1, 5'd3, 5'd8, 5'd0));
        add_inst(r_format(`CPU_FN_NOR, 5'd1, 5'd3, 5'd9, 5'd0));
        add_inst(r_format(`CPU_FN_SLT, 5'd1, 5'd2, 5'd10, 5'd0));
        add_inst(r_format(`CPU_FN_SLTU, 5'd1, 5'd2, 5'd11, 5'd0));
        add_inst(r_format(`CPU_FN_SLL, 5'd0, 5'd1, 5'd12, 5'd4));
        add_inst(r_format(`CPU_FN_SRL, 5'd0, 5'd1, 5'd13, 5'd4));
        add_inst(r_format(`CPU_FN_SRA, 5'd0, 5'd1, 5'd14, 5'd4));
        add_inst(i_format(`CPU_OP_SLTI, 5'd2, 5'd15, 16'hffff));
        add_inst(i_format(`CPU_OP_SLTIU, 5'd3, 5'd16, 16'hfff0));
        add_inst(i_format(`CPU_OP_ANDI, 5'd1, 5'd17, 16'hff0f));
        add_inst(i_format(`CPU_OP_ORI, 5'd2, 5'd18, 16'h1234));
        add_inst(i_format(`CPU_OP_XORI, 5'd1, 5'd19, 16'hffff));
        add_inst(i_format(`CPU_OP_LUI, 5'd0, 5'd20, 16'habcd));
        apply_reset();
        collect_traces("opcodes", prog_len, 0, 0, 1'b0);
    endtask

    task automatic forward_chain();
        prog_len = 0;
        add_inst(i_format(`CPU_OP_ADDIU, 5'd0, 5'd1, 16'h0007));
        add_inst(r_format(`CPU_FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
        add_inst(r_format(`CPU_FN_SUBU, 5'd2, 5'd1, 5'd3, 5'd0));
        add_inst(r_format(`CPU_FN_SLL, 5'd0, 5'd3, 5'd4, 5'd5));
        add_inst(r_format(`CPU_FN_XOR, 5'd4, 5'd3, 5'd5, 5'd0));
        add_inst(i_format(`CPU_OP_ORI, 5'd5, 5'd6, 16'h0f00));
        add_inst(r_format(`CPU_FN_NOR, 5'd6, 5'd6, 5'd7, 5'd0));
        add_inst(r_format(`CPU_FN_SRA, 5'd0, 5'd7, 5'd8, 5'd2));
        add_inst(r_format(`CPU_FN_SLT, 5'd8, 5'd7, 5'd9, 5'd0));
        add_inst(i_format(`CPU_OP_ADDIU, 5'd9, 5'd10, 16'h7fff));
        apply_reset();
        collect_traces("forwarding", prog_len, 0, 0, 1'b0);
    endtask

    task automatic order_and_r0();
        prog_len = 0;
        add_inst(i_format(`CPU_OP_ADDIU, 5'd0, 5'd0, 16'h0055));
        add_inst(r_format(`CPU_FN_ADDU, 5'd0, 5'd0, 5'd1, 5'd0));
        add_inst(i_format(`CPU_OP_LUI, 5'd0, 5'd0, 16'h1234));
        add_inst(r_format(`CPU_FN_OR, 5'd0, 5'd0, 5'd2, 5'd0));
        add_inst(i_format(`CPU_OP_ADDIU, 5'd0, 5'd3, 16'h0001));
        add_inst(r_format(`CPU_FN_SUBU, 5'd3, 5'd0, 5'd0, 5'd0));
        add_inst(r_format(`CPU_FN_ADDU, 5'd0, 5'd3, 5'd4, 5'd0));
        apply_reset();
        collect_traces("order_r0", prog_len, 0, 0, 1'b0);
    endtask

    task automatic back_pressure();
        prog_len = 0;
        for (int k = 1; k <= 16; k++) begin
            add_inst(i_format(`CPU_OP_ADDIU, 5'(k - 1), 5'(k), 16'(k)));
        end
        apply_reset();
        collect_traces("backpressure", prog_len, 8, 20, 1'b0);  // queue fills, credits run out
    endtask

    task automatic random_program();
        logic [5:0]     fn_codes [11];
        logic [5:0]     op_codes [7];
        cpu_pkg::word_t rnd;
        cpu_pkg::word_t imm;
        int             kind;
        fn_codes = '{`CPU_FN_ADDU, `CPU_FN_SUBU, `CPU_FN_AND, `CPU_FN_OR, `CPU_FN_XOR,
                     `CPU_FN_NOR, `CPU_FN_SLT, `CPU_FN_SLTU, `CPU_FN_SLL, `CPU_FN_SRL,
                     `CPU_FN_SRA};
        op_codes = '{`CPU_OP_ADDIU, `CPU_OP_ANDI, `CPU_OP_ORI, `CPU_OP_XORI,
                     `CPU_OP_LUI, `CPU_OP_SLTI, `CPU_OP_SLTIU};
        prog_len = 0;
        for (int k = 0; k < 60; k++) begin
            rnd  = next_random();
            imm  = next_random();
            kind = int'(rnd[4:0]) % 18;
            if (kind < 11) begin
                add_inst(r_format(fn_codes[kind], rnd[9:5], rnd[14:10], rnd[19:15], rnd[24:20]));
            end else begin
                add_inst(i_format(op_codes[kind - 11], rnd[9:5], rnd[14:10], imm[23:8]));
            end
        end
        apply_reset();
        collect_traces("random", prog_len, 0, 0, 1'b1);
    endtask

    initial begin
        resetn          = 1'b0;
        freeze          = 1'b0;
        inst_sram_rdata = '0;
        lcg_state       = 32'h4c90_656b;
        prog_len        = 0;
        value_errors    = 0;
        flow_errors     = 0;
        timeouts        = 0;
        reset_behavior();
        every_opcode();
        forward_chain();
        order_and_r0();
        back_pressure();
        random_program();
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, flow_errors, timeouts);
        if (value_errors + flow_errors + timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
